/* list.f */
afu_pkg.sv
wb_pkg.sv
cmd_if.sv
command_intake.sv
command_buffer.sv
command_arbiter.sv
command_control.sv
command_top.sv
tb_command_top.sv

/* Makefile */
# Verilator simulation of the command subsystem

TOP := tb_command_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_command_top.sv */
/*
  testbench for the command subsystem
  - clock, reset, wishbone write and read tasks
  - response model returning tags to the pool
  - expected queues per channel, checking assertions
*/

`timescale 1ns/1ps
`default_nettype none

module tb_command_top import afu_pkg::*, wb_pkg::*; ();

  localparam int TIMEOUT     = 400;
  localparam int ABORT_MODES = 5;
  localparam int AUTO_RESP   = 1000000;

  typedef struct packed {
    abort_mode_e abort;
    cmd_size_t   size;
    cmd_code_t   code;
    cmd_addr_t   address;
  } cmd_rec_t;

  logic        clock;
  logic        rstn;
  logic        enable;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  wb_addr_t    wb_adr;
  wb_data_t    wb_dat_w;
  wb_data_t    wb_dat_r;
  logic        wb_ack;
  logic        cmd_valid;
  cmd_code_t   cmd_code;
  cmd_addr_t   cmd_address;
  cmd_size_t   cmd_size;
  abort_mode_e cmd_abort;
  cmd_tag_t    cmd_tag;
  logic        cmd_tag_parity;
  logic        cmd_code_parity;
  logic        cmd_address_parity;
  logic        resp_valid = 1'b0;
  cmd_tag_t    resp_tag   = INVALID_TAG;

  // expected commands per channel, push order
  cmd_rec_t exp_q [NUM_CHANNELS][$];
  // tags seen on the bus and not yet returned
  cmd_tag_t outstanding [$];
  int seed            = 95;
  int errors          = 0;
  int test_mark       = 0;
  int tests_run       = 0;
  int tests_failed    = 0;
  int pushed_count    = 0;
  int issued_count    = 0;
  int resp_budget     = 0;
  int disabled_cycles = 0;

  command_top dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic record_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
  endtask

  task automatic record_failure(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // bus checks
  ////////////////////////////////////////////////////////////

  a_tag_range: assert property (@(posedge clock) disable iff (!rstn)
    cmd_valid |-> cmd_tag < cmd_tag_t'(TAG_COUNT))
    else record_mismatch($sformatf("issued tag %0d not below %0d", cmd_tag, TAG_COUNT));

  // idle bus carries the invalid tag
  a_tag_idle: assert property (@(posedge clock) disable iff (!rstn)
    !cmd_valid |-> cmd_tag == INVALID_TAG)
    else record_mismatch($sformatf("idle tag 0x%02h", cmd_tag));

  // odd parity, field plus parity bit
  a_parity: assert property (@(posedge clock) disable iff (!rstn)
    cmd_valid |-> (^{cmd_code, cmd_code_parity}) && (^{cmd_address, cmd_address_parity}))
    else record_mismatch("even parity on code or address");

  a_tag_parity: assert property (@(posedge clock) disable iff (!rstn)
    ^{cmd_tag, cmd_tag_parity})
    else record_mismatch("even parity on tag");

  // two cycles of slack: registered enable, then latch and output
  a_enable_drop: assert property (@(posedge clock) disable iff (!rstn)
    cmd_valid |-> enable || disabled_cycles <= 2)
    else record_mismatch($sformatf("cmd_valid %0d cycles after enable drop", disabled_cycles));

  always @(posedge clock) begin
    if (enable) begin
      disabled_cycles <= 0;
    end else if (disabled_cycles < 100) begin
      disabled_cycles <= disabled_cycles + 1;
    end
  end

  // monitor, compares each issued command with its channel queue
  always @(posedge clock) begin
    chan_id_t ch;
    cmd_rec_t exp;
    if (rstn && cmd_valid) begin
      ch = chan_id_t'(cmd_address[1:0]);
      issued_count++;
      if (exp_q[ch].size() == 0) begin
        record_failure($sformatf("command issued on channel %0d with none pending", ch));
      end else begin
        exp = exp_q[ch].pop_front();
        assert (cmd_code == exp.code && cmd_address == exp.address &&
                cmd_size == exp.size && cmd_abort == exp.abort)
          else record_mismatch($sformatf("ch %0d code %h addr %h, expected %h %h",
                                         ch, cmd_code, cmd_address, exp.code, exp.address));
      end
      foreach (outstanding[i]) begin
        assert (outstanding[i] != cmd_tag)
          else record_mismatch($sformatf("tag %0d issued while outstanding", cmd_tag));
      end
      outstanding.push_back(cmd_tag);
    end
  end

  // response model, one tag per cycle while budget remains
  always @(posedge clock) begin
    #1;
    if (resp_budget > 0 && outstanding.size() > 0) begin
      resp_valid = 1'b1;
      resp_tag   = outstanding.pop_front();
      resp_budget--;
    end else begin
      resp_valid = 1'b0;
      resp_tag   = INVALID_TAG;
    end
  end

  ////////////////////////////////////////////////////////////
  // wishbone and command tasks
  ////////////////////////////////////////////////////////////

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic wb_start(input wb_addr_t adr, input wb_data_t dat, input logic we);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
  endtask

  // ack sampled 1 ns after the edge, cycle ends there
  task automatic wb_wait_ack(output logic acked);
    int n;
    n     = 0;
    acked = 1'b0;
    while (!acked && n < TIMEOUT) begin
      @(posedge clock);
      #1;
      acked = wb_ack;
      n++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!acked) record_failure($sformatf("no ack for access to 0x%02h", wb_adr));
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    logic acked;
    wb_start(adr, dat, 1'b1);
    wb_wait_ack(acked);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    logic acked;
    wb_start(adr, '0, 1'b0);
    wb_wait_ack(acked);
    dat = wb_dat_r;
  endtask

  // channel goes into address bits 1..0
  task automatic stage_cmd(input chan_id_t ch, input cmd_code_t code, input cmd_addr_t addr,
                           input cmd_size_t size, input abort_mode_e abort);
    cmd_rec_t rec;
    rec.address = {addr[63:2], ch};
    rec.code    = code;
    rec.size    = size;
    rec.abort   = abort;
    wb_write(REG_ADDR_LO, rec.address[31:0]);
    wb_write(REG_ADDR_HI, rec.address[63:32]);
    wb_write(REG_CMD, {1'b0, rec.abort, rec.size, 3'b000, rec.code});
    exp_q[ch].push_back(rec);
    pushed_count++;
  endtask

  task automatic stage_random(input chan_id_t ch);
    cmd_addr_t addr;
    cmd_code_t code;
    cmd_size_t size;
    abort_mode_e abort;
    addr  = {$random(seed), $random(seed)};
    code  = cmd_code_t'($random(seed));
    size  = cmd_size_t'($random(seed));
    abort = abort_mode_e'(3'($unsigned($random(seed)) % ABORT_MODES));
    stage_cmd(ch, code, addr, size, abort);
  endtask

  task automatic send_go(input chan_id_t ch);
    wb_write(REG_GO, wb_data_t'(ch));
  endtask

  task automatic random_cmd(input chan_id_t ch);
    stage_random(ch);
    send_go(ch);
  endtask

  task automatic wait_issued(input int n);
    int cycles;
    cycles = 0;
    while (issued_count < n && cycles < TIMEOUT) begin
      run_cycles(1);
      cycles++;
    end
    if (issued_count < n) begin
      record_failure($sformatf("only %0d of %0d commands issued", issued_count, n));
    end
  endtask

  // until the response model has nothing left to send
  task automatic wait_responses();
    int cycles;
    cycles = 0;
    while (((resp_budget > 0 && outstanding.size() > 0) || resp_valid) && cycles < TIMEOUT) begin
      run_cycles(1);
      cycles++;
    end
    if (resp_valid) record_failure("responses still pending");
  endtask

  // free count from the tags the monitor holds
  task automatic check_status(input logic [NUM_CHANNELS-1:0] full);
    wb_data_t rd;
    wb_data_t exp;
    exp                   = '0;
    exp[NUM_CHANNELS-1:0] = full;
    exp[11:8]             = 4'(TAG_COUNT - outstanding.size());
    wb_read(REG_STATUS, rd);
    assert (rd == exp)
      else record_mismatch($sformatf("STATUS 0x%08h, expected 0x%08h", rd, exp));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_mark) tests_failed++;
    $display("test %-14s %s", name, (errors == test_mark) ? "ok" : "failed");
    test_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int base;
    rstn     = 1'b0;
    enable   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (5) @(posedge clock);
    #1;
    rstn = 1'b1;

    assert (!cmd_valid && !wb_ack && cmd_tag == INVALID_TAG)
      else record_mismatch("outputs not idle after reset");
    check_status('0);
    finish_test("reset");

    // random traffic, tags return as they appear
    enable      = 1'b1;
    resp_budget = AUTO_RESP;
    for (int i = 0; i < 24; i++) random_cmd(chan_id_t'($random(seed)));
    wait_issued(pushed_count);
    wait_responses();
    finish_test("round_trip");

    // all ones, all zeros, alternating
    stage_cmd(0, '1, '1, '1, SPEC);
    send_go(0);
    stage_cmd(1, '0, '0, '0, STRICT);
    send_go(1);
    stage_cmd(3, 13'h1555, 64'hAAAA_5555_0F0F_F0F0, 12'h801, PAGE);
    send_go(3);
    wait_issued(pushed_count);
    wait_responses();
    finish_test("parity");

    // pool runs dry, then partial returns
    resp_budget = 0;
    base        = issued_count;
    for (int i = 0; i < TAG_COUNT + 2; i++) random_cmd(chan_id_t'(i));
    wait_issued(base + TAG_COUNT);
    run_cycles(12);
    assert (issued_count == base + TAG_COUNT)
      else record_mismatch($sformatf("%0d issued with no tags, expected %0d",
                                     issued_count - base, TAG_COUNT));
    check_status('0);
    resp_budget = 2;
    wait_issued(base + TAG_COUNT + 2);
    wait_responses();
    check_status('0);
    resp_budget = 3;
    wait_responses();
    check_status('0);
    resp_budget = AUTO_RESP;
    wait_responses();
    finish_test("tag_pool");

    // drop right after a push, so one command is in flight
    for (int i = 0; i < 3; i++) random_cmd(chan_id_t'(i));
    enable = 1'b0;
    for (int i = 0; i < 5; i++) random_cmd(chan_id_t'(i));
    run_cycles(10);
    assert (issued_count == pushed_count - 5)
      else record_mismatch($sformatf("%0d commands issued while disabled",
                                     issued_count - (pushed_count - 5)));
    enable = 1'b1;
    wait_issued(pushed_count);
    wait_responses();
    finish_test("enable");

    // fill channel 2, next GO stalls in a wait state
    enable = 1'b0;
    for (int i = 0; i < BUFFER_DEPTH; i++) random_cmd(2);
    check_status(4'b0100);
    stage_random(2);
    wb_start(REG_GO, 32'd2, 1'b1);
    for (int i = 0; i < 10; i++) begin
      run_cycles(1);
      assert (!wb_ack) else record_mismatch("GO write to a full channel was acked");
    end
    enable = 1'b1;
    begin
      logic acked;
      wb_wait_ack(acked);
    end
    wait_issued(pushed_count);
    wait_responses();
    finish_test("back_pressure");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* command_top.sv */
/*
  command subsystem top
  - wishbone intake, per-channel buffers, arbiter, issue stage
  - plain ports, interfaces inside
*/

`timescale 1ns/1ps
`default_nettype none

module command_top import afu_pkg::*, wb_pkg::*; (
  input  wire            clock,
  input  wire            rstn,
  input  wire            enable,
  input  wire            wb_cyc,
  input  wire            wb_stb,
  input  wire            wb_we,
  input  wire  wb_addr_t wb_adr,
  input  wire  wb_data_t wb_dat_w,
  output wb_data_t       wb_dat_r,
  output logic           wb_ack,
  output logic           cmd_valid,
  output cmd_code_t      cmd_code,
  output cmd_addr_t      cmd_address,
  output cmd_size_t      cmd_size,
  output abort_mode_e    cmd_abort,
  output cmd_tag_t       cmd_tag,
  output logic           cmd_tag_parity,
  output logic           cmd_code_parity,
  output logic           cmd_address_parity,
  input  wire            resp_valid,
  input  wire  cmd_tag_t resp_tag
);

  // intake to buffers, buffers to arbiter
  cmd_push_if  push_bus [NUM_CHANNELS] ();
  cmd_push_if  head_bus [NUM_CHANNELS] ();
  cmd_issue_if issue_bus ();

  logic [NUM_CHANNELS-1:0] chan_full;
  tag_count_t free_tags;

  command_intake u_intake (
    .clock     (clock),
    .rstn      (rstn),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .push      (push_bus),
    .chan_full (chan_full),
    .free_tags (free_tags)
  );

  // one buffer per channel
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_buf
    command_buffer u_buffer (
      .clock (clock),
      .rstn  (rstn),
      .push  (push_bus[c]),
      .pop   (head_bus[c]),
      .full  (chan_full[c])
    );
  end

  command_arbiter u_arbiter (
    .clock      (clock),
    .rstn       (rstn),
    .heads      (head_bus),
    .issue      (issue_bus),
    .resp_valid (resp_valid),
    .resp_tag   (resp_tag),
    .free_tags  (free_tags)
  );

  command_control u_control (
    .clock              (clock),
    .rstn               (rstn),
    .enable             (enable),
    .issue              (issue_bus),
    .cmd_valid          (cmd_valid),
    .cmd_code           (cmd_code),
    .cmd_address        (cmd_address),
    .cmd_size           (cmd_size),
    .cmd_abort          (cmd_abort),
    .cmd_tag            (cmd_tag),
    .cmd_tag_parity     (cmd_tag_parity),
    .cmd_code_parity    (cmd_code_parity),
    .cmd_address_parity (cmd_address_parity)
  );

endmodule

`default_nettype wire

/* command_control.sv */
/*
  command issue stage
  - registered enable, offered as ready
  - issue latch with tag
  - odd parity on tag, code, address
  - registered command bus
*/

`timescale 1ns/1ps
`default_nettype none

module command_control import afu_pkg::*; (
  input  wire         clock,
  input  wire         rstn,
  input  wire         enable,
  cmd_issue_if.sink   issue,
  output logic        cmd_valid,
  output cmd_code_t   cmd_code,
  output cmd_addr_t   cmd_address,
  output cmd_size_t   cmd_size,
  output abort_mode_e cmd_abort,
  output cmd_tag_t    cmd_tag,
  output logic        cmd_tag_parity,
  output logic        cmd_code_parity,
  output logic        cmd_address_parity
);

  logic        enable_q;
  logic        issue_fire;
  logic        lat_valid;
  cmd_code_t   lat_code;
  cmd_addr_t   lat_addr;
  cmd_size_t   lat_size;
  abort_mode_e lat_abort;
  cmd_tag_t    lat_tag;
  cmd_tag_t    tag_out;

  assign issue.ready = enable_q;
  assign issue_fire  = issue.valid && issue.ready;
  // idle bus shows the invalid tag
  assign tag_out     = lat_valid ? lat_tag : INVALID_TAG;

  ////////////////////////////////////////////////////////////
  // enable and issue latch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enable_q  <= 1'b0;
      lat_valid <= 1'b0;
    end else begin
      enable_q  <= enable;
      lat_valid <= issue_fire;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_fire) begin
      lat_code  <= issue.code;
      lat_addr  <= issue.address;
      lat_size  <= issue.size;
      lat_abort <= issue.abort;
      lat_tag   <= issue.tag;
    end
  end

  ////////////////////////////////////////////////////////////
  // command bus, odd parity
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_valid      <= 1'b0;
      cmd_tag        <= INVALID_TAG;
      cmd_tag_parity <= ~^INVALID_TAG;
    end else begin
      cmd_valid      <= lat_valid;
      cmd_tag        <= tag_out;
      cmd_tag_parity <= ~^tag_out;
    end
  end

  always_ff @(posedge clock) begin
    cmd_code           <= lat_code;
    cmd_address        <= lat_addr;
    cmd_size           <= lat_size;
    cmd_abort          <= lat_abort;
    cmd_code_parity    <= ~^lat_code;
    cmd_address_parity <= ~^lat_addr;
  end

  a_valid_known: assert property (@(posedge clock) disable iff (!rstn)
    !$isunknown(cmd_valid));

endmodule

`default_nettype wire

/* command_arbiter.sv */
/*
  command arbiter
  - round-robin over the channel buffer heads
  - tag pool, lowest free tag on issue, release on response
  - free tag count for status
*/

`timescale 1ns/1ps
`default_nettype none

module command_arbiter import afu_pkg::*; (
  input  wire            clock,
  input  wire            rstn,
  cmd_push_if.sink       heads [NUM_CHANNELS],
  cmd_issue_if.source    issue,
  input  wire            resp_valid,
  input  wire  cmd_tag_t resp_tag,
  output tag_count_t     free_tags
);

  logic [NUM_CHANNELS-1:0] head_valid;
  cmd_code_t   head_code  [NUM_CHANNELS];
  cmd_addr_t   head_addr  [NUM_CHANNELS];
  cmd_size_t   head_size  [NUM_CHANNELS];
  abort_mode_e head_abort [NUM_CHANNELS];
  chan_id_t    last_grant;
  chan_id_t    sel;
  logic        any_valid;
  logic [TAG_COUNT-1:0] in_use;
  tag_idx_t    free_idx;
  logic        tag_avail;
  logic        issue_fire;
  tag_idx_t    resp_idx;

  // gather heads, pop only the granted channel
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_heads
    assign head_valid[c] = heads[c].valid;
    assign head_code[c]  = heads[c].code;
    assign head_addr[c]  = heads[c].address;
    assign head_size[c]  = heads[c].size;
    assign head_abort[c] = heads[c].abort;
    assign heads[c].ready = issue_fire && (sel == chan_id_t'(c));
  end

  ////////////////////////////////////////////////////////////
  // round-robin select
  ////////////////////////////////////////////////////////////

  // search starts one past the last grant, wraps on chan_id_t
  always_comb begin
    chan_id_t cand;
    sel       = last_grant;
    any_valid = 1'b0;
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      cand = last_grant + chan_id_t'(i);
      if (!any_valid && head_valid[cand]) begin
        sel       = cand;
        any_valid = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tag pool
  ////////////////////////////////////////////////////////////

  // lowest free tag wins, downward scan
  always_comb begin
    free_idx  = '0;
    tag_avail = 1'b0;
    free_tags = '0;
    for (int t = TAG_COUNT - 1; t >= 0; t--) begin
      if (!in_use[t]) begin
        free_idx  = tag_idx_t'(t);
        tag_avail = 1'b1;
        free_tags = free_tags + 1'b1;
      end
    end
  end

  // grant only with a tag and a ready issue stage
  assign issue.valid   = any_valid && tag_avail && issue.ready;
  assign issue_fire    = issue.valid && issue.ready;
  assign issue.code    = head_code[sel];
  assign issue.address = head_addr[sel];
  assign issue.size    = head_size[sel];
  assign issue.abort   = head_abort[sel];
  assign issue.tag     = cmd_tag_t'(free_idx);

  assign resp_idx = tag_idx_t'(resp_tag);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      // channel 0 first after reset
      last_grant <= chan_id_t'(NUM_CHANNELS - 1);
      in_use     <= '0;
    end else begin
      if (issue_fire) last_grant <= sel;
      // freed tag usable next cycle
      if (resp_valid) in_use[resp_idx] <= 1'b0;
      if (issue_fire) in_use[free_idx] <= 1'b1;
    end
  end

  // response names an outstanding tag
  a_resp_tag: assert property (@(posedge clock) disable iff (!rstn)
    resp_valid |-> (resp_tag < TAG_COUNT) && in_use[resp_idx]);

  // issued tag not outstanding
  a_issue_tag: assert property (@(posedge clock) disable iff (!rstn)
    issue_fire |-> !in_use[free_idx]);

endmodule

`default_nettype wire

/* command_buffer.sv */
/*
  per-channel command buffer
  - BUFFER_DEPTH entry FIFO with count register
  - head visible the cycle after a push
*/

`timescale 1ns/1ps
`default_nettype none

module command_buffer import afu_pkg::*; (
  input  wire        clock,
  input  wire        rstn,
  cmd_push_if.sink   push,
  cmd_push_if.source pop,
  output logic       full
);

  cmd_code_t   mem_code  [BUFFER_DEPTH];
  cmd_addr_t   mem_addr  [BUFFER_DEPTH];
  cmd_size_t   mem_size  [BUFFER_DEPTH];
  abort_mode_e mem_abort [BUFFER_DEPTH];
  buf_ptr_t    wr_ptr;
  buf_ptr_t    rd_ptr;
  buf_count_t  count;
  logic        push_fire;
  logic        pop_fire;

  function automatic buf_ptr_t next_ptr(input buf_ptr_t p);
    return (p == buf_ptr_t'(BUFFER_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full       = (count == buf_count_t'(BUFFER_DEPTH));
  assign push.ready = !full;
  assign push_fire  = push.valid && push.ready;
  assign pop_fire   = pop.valid && pop.ready;

  // head of queue
  assign pop.valid   = (count != '0);
  assign pop.code    = mem_code[rd_ptr];
  assign pop.address = mem_addr[rd_ptr];
  assign pop.size    = mem_size[rd_ptr];
  assign pop.abort   = mem_abort[rd_ptr];

  // storage
  always_ff @(posedge clock) begin
    if (push_fire) begin
      mem_code[wr_ptr]  <= push.code;
      mem_addr[wr_ptr]  <= push.address;
      mem_size[wr_ptr]  <= push.size;
      mem_abort[wr_ptr] <= push.abort;
    end
  end

  // pointers and fill level
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) wr_ptr <= next_ptr(wr_ptr);
      if (pop_fire)  rd_ptr <= next_ptr(rd_ptr);
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // no push taken while full
  a_no_push_full: assert property (@(posedge clock) disable iff (!rstn)
    push_fire |-> count < buf_count_t'(BUFFER_DEPTH));

endmodule

`default_nettype wire

/* command_intake.sv */
/*
  command intake
  - wishbone classic slave, one-cycle ack
  - staging registers for address, code, size, abort
  - go write pushes to the selected channel, ack waits for room
  - status read of full flags and free tags
*/

`timescale 1ns/1ps
`default_nettype none

module command_intake import afu_pkg::*, wb_pkg::*; (
  input  wire              clock,
  input  wire              rstn,
  input  wire              wb_cyc,
  input  wire              wb_stb,
  input  wire              wb_we,
  input  wire  wb_addr_t   wb_adr,
  input  wire  wb_data_t   wb_dat_w,
  output wb_data_t         wb_dat_r,
  output logic             wb_ack,
  cmd_push_if.source       push [NUM_CHANNELS],
  input  wire  [NUM_CHANNELS-1:0] chan_full,
  input  wire  tag_count_t free_tags
);

  cmd_addr_t   stage_addr;
  cmd_code_t   stage_code;
  cmd_size_t   stage_size;
  abort_mode_e stage_abort;
  logic        access;
  logic        wr_access;
  logic        go_req;
  chan_id_t    go_chan;
  logic [NUM_CHANNELS-1:0] chan_ready;
  wb_data_t    rd_data;

  // new cycle only, the ack cycle is not a second access
  assign access    = wb_cyc && wb_stb && !wb_ack;
  assign wr_access = access && wb_we;
  assign go_req    = wr_access && (wb_adr == REG_GO);
  assign go_chan   = chan_id_t'(wb_dat_w[1:0]);

  ////////////////////////////////////////////////////////////
  // staging registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (wr_access) begin
      case (wb_adr)
        REG_ADDR_LO: stage_addr[31:0]  <= wb_dat_w;
        REG_ADDR_HI: stage_addr[63:32] <= wb_dat_w;
        REG_CMD: begin
          stage_code  <= wb_dat_w[12:0];
          stage_size  <= wb_dat_w[27:16];
          stage_abort <= abort_mode_e'(wb_dat_w[30:28]);
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // push to channels
  ////////////////////////////////////////////////////////////

  // master holds stb until ack, so valid and fields stay put
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_push
    assign push[c].valid   = go_req && (go_chan == chan_id_t'(c));
    assign push[c].code    = stage_code;
    assign push[c].address = stage_addr;
    assign push[c].size    = stage_size;
    assign push[c].abort   = stage_abort;
    assign chan_ready[c]   = push[c].ready;
  end

  // read mux
  always_comb begin
    rd_data = '0;
    case (wb_adr)
      REG_ADDR_LO: rd_data = stage_addr[31:0];
      REG_ADDR_HI: rd_data = stage_addr[63:32];
      REG_CMD: begin
        rd_data[12:0]  = stage_code;
        rd_data[27:16] = stage_size;
        rd_data[30:28] = stage_abort;
      end
      REG_STATUS: begin
        rd_data[NUM_CHANNELS-1:0] = chan_full;
        rd_data[11:8]             = free_tags;
      end
      default: ;
    endcase
  end

  // ack next cycle, go stalls while its channel is full
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
    end else begin
      wb_ack <= access && (!go_req || chan_ready[go_chan]);
      if (access && !wb_we) begin
        wb_dat_r <= rd_data;
      end
    end
  end

endmodule

`default_nettype wire

/* cmd_if.sv */
/*
  internal command handshakes
  - cmd_push_if: command without tag, intake to buffer, buffer to arbiter
  - cmd_issue_if: tagged command, arbiter to issue stage
*/

`timescale 1ns/1ps
`default_nettype none

interface cmd_push_if import afu_pkg::*; ();
  logic        valid;
  logic        ready;
  cmd_code_t   code;
  cmd_addr_t   address;
  cmd_size_t   size;
  abort_mode_e abort;

  // transfer on valid && ready
  modport source (output valid, code, address, size, abort, input ready);
  modport sink   (input valid, code, address, size, abort, output ready);
endinterface

interface cmd_issue_if import afu_pkg::*; ();
  logic        valid;
  logic        ready;
  cmd_code_t   code;
  cmd_addr_t   address;
  cmd_size_t   size;
  abort_mode_e abort;
  cmd_tag_t    tag;

  // ready is the registered enable of the issue stage
  modport source (output valid, code, address, size, abort, tag, input ready);
  modport sink   (input valid, code, address, size, abort, tag, output ready);
endinterface

`default_nettype wire

/* wb_pkg.sv */
/*
  wishbone slave definitions
  - address and data widths
  - register map offsets of the command port
*/

`default_nettype none

package wb_pkg;

  localparam int WB_ADDR_W = 8;
  localparam int WB_DATA_W = 32;

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [WB_DATA_W-1:0] wb_data_t;

  ////////////////////////////////////////////////////////////
  // register map, byte offsets
  ////////////////////////////////////////////////////////////

  // effective address, low and high word
  localparam wb_addr_t REG_ADDR_LO = 8'h00;
  localparam wb_addr_t REG_ADDR_HI = 8'h04;
  // code [12:0], size [27:16], abort [30:28]
  localparam wb_addr_t REG_CMD     = 8'h08;
  // write pushes staged command, channel in [1:0]
  localparam wb_addr_t REG_GO      = 8'h0C;
  // full flags [3:0], free tag count [11:8]
  localparam wb_addr_t REG_STATUS  = 8'h10;

endpackage

`default_nettype wire

/* afu_pkg.sv */
/*
  accelerator command definitions
  - command field types: code, address, size, tag
  - abort mode encoding
  - channel count, buffer depth and tag pool constants
*/

`default_nettype none

package afu_pkg;

  ////////////////////////////////////////////////////////////
  // command fields
  ////////////////////////////////////////////////////////////

  typedef logic [12:0] cmd_code_t;
  typedef logic [63:0] cmd_addr_t;
  typedef logic [11:0] cmd_size_t;
  typedef logic [7:0]  cmd_tag_t;

  // abort modes, bus encoding
  typedef enum logic [2:0] {
    STRICT = 3'b000,
    ABORT  = 3'b001,
    PAGE   = 3'b010,
    PREF   = 3'b011,
    SPEC   = 3'b100
  } abort_mode_e;

  ////////////////////////////////////////////////////////////
  // channels and buffers
  ////////////////////////////////////////////////////////////

  localparam int NUM_CHANNELS = 4;
  typedef logic [1:0] chan_id_t;

  // entries per channel buffer
  localparam int BUFFER_DEPTH = 4;
  localparam int BUF_PTR_W    = $clog2(BUFFER_DEPTH);
  typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
  // one bit wider, holds 0..BUFFER_DEPTH
  typedef logic [BUF_PTR_W:0]   buf_count_t;

  ////////////////////////////////////////////////////////////
  // tag pool
  ////////////////////////////////////////////////////////////

  // tags 0..TAG_COUNT-1 in use
  localparam int TAG_COUNT = 8;
  localparam int TAG_IDX_W = $clog2(TAG_COUNT);
  typedef logic [TAG_IDX_W-1:0] tag_idx_t;
  // free count, up to TAG_COUNT
  typedef logic [3:0] tag_count_t;

  // idle value on the tag lines
  localparam cmd_tag_t INVALID_TAG = 8'hFF;

endpackage

`default_nettype wire
